// ==== run_sim.sh ====
#!/bin/sh
# compile and run the dvi testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module dvi_tb \
  -Mdir obj_dir -o dvi_sim

if ! ./obj_dir/dvi_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi
cat sim.log

if grep -q '^>>> FAIL' sim.log; then
  exit 1
fi
grep -q '^>>> PASS' sim.log

// ==== src/dvi_ddr_out.sv ====
// ======================================================================
// one pixel per active cycle, lane lo then lane hi; all outputs lag by one
// a pair whose lo half found the fifo empty is skipped whole
// ======================================================================
`default_nettype none

module dvi_ddr_out
  import dvi_pixel_pkg::*;
(
  input  wire         clock,
  input  wire         reset,
  input  pixel_pair_t head,
  input  wire         empty,
  dvi_sync_if.sink    sync,
  output logic        pop,
  output logic        hs,
  output logic        vs,
  output logic        de,
  output logic [11:0] d_rise,
  output logic [11:0] d_fall,
  output logic        underflow
);

  logic offset;         // 1 while showing lane hi
  logic lo_missed;      // lo half of this pair was not shown
  logic eff_offset;
  logic gap;
  pixel_t pixel;

  assign eff_offset = sync.line_start ? 1'b0 : offset;
  assign pixel = eff_offset ? head.hi : head.lo;
  assign gap = sync.de && (empty || (eff_offset && lo_missed));
  assign pop = sync.de && eff_offset && !gap;   // word done after lane hi

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      offset <= 1'b0;
      lo_missed <= 1'b0;
      hs <= 1'b1;
      vs <= 1'b1;
      de <= 1'b0;
      underflow <= 1'b0;
    end else begin
      hs <= sync.hs;
      vs <= sync.vs;
      de <= sync.de;
      if (sync.de) begin
        offset <= ~eff_offset;    // toggles even on underflow
        lo_missed <= !eff_offset && empty;
      end else begin
        offset <= eff_offset;
      end
      if (gap) underflow <= 1'b1;   // sticky
    end
  end

  // ====================================================================
  // ddr halves: rise = g[3:0],b   fall = r,g[7:4]
  // ====================================================================
  always_ff @(posedge clock) begin
    if (sync.de && !gap) begin
      d_rise <= {pixel.green[3:0], pixel.blue};
      d_fall <= {pixel.red, pixel.green[7:4]};
    end else begin
      d_rise <= 12'h000;
      d_fall <= 12'h000;
    end
  end

endmodule

`default_nettype wire

// ==== src/dvi_iic_init.sv ====
// ======================================================================
// one-shot i2c writer for the encoder register table, no clock stretching
// sda_oe high pulls sda low; a nak halts with error and done stays low
// ======================================================================
`include "dvi_macros.svh"
`default_nettype none

module dvi_iic_init
  import dvi_pixel_pkg::*;
(
  input  wire  clock,
  input  wire  reset,
  input  wire  sda_in,
  output logic scl,
  output logic sda_oe,
  output logic done,
  output logic error
);

  localparam int COUNT = `DVI_IIC_COUNT;
  localparam int EW = (COUNT > 1) ? $clog2(COUNT) : 1;
  localparam int DW = (`DVI_IIC_DIV > 1) ? $clog2(`DVI_IIC_DIV) : 1;
  localparam logic [COUNT*16-1:0] TABLE = `DVI_IIC_TABLE;
  localparam logic [7:0] ADDR_BYTE = {7'(`DVI_IIC_ADDR), 1'b0};   // write

  iic_state_t state;
  logic [DW-1:0] div_cnt;
  logic [1:0] quarter;
  logic [2:0] bit_idx;
  logic [1:0] byte_idx;       // address, register, value
  logic [EW-1:0] entry;
  logic [15:0] entry_word;
  logic [7:0] cur_byte;
  logic busy, tick, scl_next, sda_next;

  assign busy = (state == IIC_START) || (state == IIC_DATA) ||
                (state == IIC_ACK) || (state == IIC_STOP);
  assign tick = busy && (div_cnt == DW'(`DVI_IIC_DIV - 1));
  assign entry_word = TABLE[entry*16 +: 16];

  always_comb begin
    case (byte_idx)
      2'd0:    cur_byte = ADDR_BYTE;
      2'd1:    cur_byte = entry_word[15:8];
      default: cur_byte = entry_word[7:0];
    endcase
  end

  // bus levels per quarter; scl is high in quarters 1 and 2 of a bit
  always_comb begin
    scl_next = 1'b1;
    sda_next = 1'b0;
    case (state)
      IIC_START: begin
        scl_next = (quarter != 2'd3);
        sda_next = (quarter != 2'd0);   // sda falls while scl high
      end
      IIC_DATA: begin
        scl_next = (quarter == 2'd1) || (quarter == 2'd2);
        sda_next = ~cur_byte[bit_idx];
      end
      IIC_ACK: begin
        scl_next = (quarter == 2'd1) || (quarter == 2'd2);
      end
      IIC_STOP: begin
        scl_next = (quarter != 2'd0);
        sda_next = (quarter <= 2'd1);   // sda rises while scl high
      end
      default: ;
    endcase
  end

  // ====================================================================
  // sequencer
  // ====================================================================
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= IIC_IDLE;
      div_cnt <= '0;
      quarter <= 2'd0;
      bit_idx <= 3'd7;
      byte_idx <= 2'd0;
      entry <= '0;
      scl <= 1'b1;
      sda_oe <= 1'b0;
    end else begin
      scl <= scl_next;
      sda_oe <= sda_next;
      if (state == IIC_IDLE) begin
        state <= IIC_START;
      end else if (tick) begin
        div_cnt <= '0;
        quarter <= quarter + 2'd1;
        if (state == IIC_ACK && quarter == 2'd2 && sda_in) begin
          state <= IIC_ERROR;     // no ack from the encoder
        end else if (quarter == 2'd3) begin
          case (state)
            IIC_START: begin
              state <= IIC_DATA;
              bit_idx <= 3'd7;
              byte_idx <= 2'd0;
            end
            IIC_DATA: begin
              if (bit_idx == 3'd0) state <= IIC_ACK;
              else bit_idx <= bit_idx - 3'd1;
            end
            IIC_ACK: begin
              if (byte_idx == 2'd2) begin
                state <= IIC_STOP;
              end else begin
                byte_idx <= byte_idx + 2'd1;
                bit_idx <= 3'd7;
                state <= IIC_DATA;
              end
            end
            IIC_STOP: begin
              if (entry == EW'(COUNT - 1)) begin
                state <= IIC_DONE;
              end else begin
                entry <= entry + 1'b1;
                state <= IIC_START;
              end
            end
            default: ;
          endcase
        end
      end else if (busy) begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  assign done = (state == IIC_DONE);
  assign error = (state == IIC_ERROR);

endmodule

`default_nettype wire

// ==== src/dvi_macros.svh ====
// ======================================================================
// raster, buffer and encoder setup constants, sized for simulation
// table entries are {register, value}; entry 0 sits in the lowest bits
// ======================================================================
`ifndef DVI_MACROS_SVH
`define DVI_MACROS_SVH

// ======================================================================
// raster timing in pixel clocks and lines
// ======================================================================
`define DVI_H_ACTIVE 16
`define DVI_H_FRONT 2
`define DVI_H_SYNC 4
`define DVI_H_BACK 4

`define DVI_V_ACTIVE 6
`define DVI_V_FRONT 1
`define DVI_V_SYNC 2
`define DVI_V_BACK 1

// fifo words, also the credits the source starts with
`define DVI_BUF_DEPTH 8

// ======================================================================
// encoder i2c setup
// ======================================================================
`define DVI_IIC_ADDR 7'h76
`define DVI_IIC_DIV 4       // clocks per scl quarter period
`define DVI_IIC_COUNT 4
// power management last so the encoder wakes fully configured
`define DVI_IIC_TABLE {16'h49C0, 16'h3308, 16'h2109, 16'h1C04}

`endif

// ==== src/dvi_pixel_buffer.sv ====
// ======================================================================
// word fifo for the credited source; no ready, the credits prevent overflow
// head is valid while empty is low; one credit returns per pop, a cycle late
// ======================================================================
`include "dvi_macros.svh"
`default_nettype none

module dvi_pixel_buffer
  import dvi_pixel_pkg::*;
#(
  parameter int DEPTH = `DVI_BUF_DEPTH
) (
  input  wire         clock,
  input  wire         reset,
  input  wire         word_valid,
  input  wire  [63:0] word_data,
  input  wire         pop,
  output pixel_pair_t head,
  output logic        empty,
  output logic        credit_return
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

  pixel_pair_t mem [DEPTH];
  logic [AW-1:0] wptr;
  logic [AW-1:0] rptr;
  logic [AW:0] count;
  logic full, push_ok, pop_ok;

  assign empty = (count == '0);
  assign full = (count == (AW + 1)'(DEPTH));
  assign pop_ok = pop && !empty;
  assign push_ok = word_valid && (!full || pop_ok);
  assign head = mem[rptr];   // first-word fall-through

  always_ff @(posedge clock) begin
    if (push_ok) mem[wptr] <= pixel_pair_t'(word_data);
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wptr <= '0;
      rptr <= '0;
      count <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop_ok;
      if (push_ok) wptr <= (wptr == LAST) ? '0 : wptr + 1'b1;
      if (pop_ok) rptr <= (rptr == LAST) ? '0 : rptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/dvi_pixel_pkg.sv ====
// ======================================================================
// pixel lanes are 32 bits wide and the top byte of each is ignored
// lane lo is shown before lane hi
// ======================================================================
`default_nettype none

package dvi_pixel_pkg;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } pixel_t;

  typedef struct packed {
    logic [7:0] hi_pad;     // unused
    pixel_t     hi;
    logic [7:0] lo_pad;     // unused
    pixel_t     lo;
  } pixel_pair_t;

  // i2c setup sequencer
  typedef enum logic [2:0] {
    IIC_IDLE,
    IIC_START,
    IIC_DATA,
    IIC_ACK,
    IIC_STOP,
    IIC_DONE,
    IIC_ERROR
  } iic_state_t;

endpackage

`default_nettype wire

// ==== src/dvi_sync_gen.sv ====
// ======================================================================
// raster counters; with run low they sit at h 0, v 0 and sync is idle
// hs and vs are active low
// ======================================================================
`default_nettype none

module dvi_sync_gen
  import dvi_timing_pkg::*;
(
  input  wire        clock,
  input  wire        reset,
  input  wire        run,
  dvi_sync_if.source sync
);

  localparam h_count_t H_LAST = h_count_t'(H_TOTAL - 1);
  localparam v_count_t V_LAST = v_count_t'(V_TOTAL - 1);

  h_count_t h;
  v_count_t v;
  sync_phase_t h_phase;
  sync_phase_t v_phase;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      h <= '0;
      v <= '0;
    end else if (!run) begin
      h <= '0;
      v <= '0;
    end else if (h == H_LAST) begin
      h <= '0;
      v <= (v == V_LAST) ? '0 : v + 1'b1;   // new frame after the last line
    end else begin
      h <= h + 1'b1;
    end
  end

  // phase decode
  always_comb begin
    if (h < h_count_t'(H_ACTIVE)) h_phase = PHASE_ACTIVE;
    else if (h < h_count_t'(H_SYNC_BEGIN)) h_phase = PHASE_FRONT;
    else if (h < h_count_t'(H_SYNC_END)) h_phase = PHASE_SYNC;
    else h_phase = PHASE_BACK;

    if (v < v_count_t'(V_ACTIVE)) v_phase = PHASE_ACTIVE;
    else if (v < v_count_t'(V_SYNC_BEGIN)) v_phase = PHASE_FRONT;
    else if (v < v_count_t'(V_SYNC_END)) v_phase = PHASE_SYNC;
    else v_phase = PHASE_BACK;
  end

  assign sync.hs = !(run && h_phase == PHASE_SYNC);
  assign sync.vs = !(run && v_phase == PHASE_SYNC);
  assign sync.de = run && (h_phase == PHASE_ACTIVE) && (v_phase == PHASE_ACTIVE);
  assign sync.line_start = run && (h == '0);

endmodule

`default_nettype wire

// ==== src/dvi_sync_if.sv ====
// ======================================================================
// sync bundle from the sync generator to the output stage
// hs and vs are active low; line_start marks h 0
// ======================================================================
`default_nettype none

interface dvi_sync_if;

  logic hs;
  logic vs;
  logic de;
  logic line_start;

  modport source (output hs, vs, de, line_start);
  modport sink (input hs, vs, de, line_start);

endinterface

`default_nettype wire

// ==== src/dvi_timing_pkg.sv ====
// ======================================================================
// raster counter types and phase boundaries, taken from the macros
// ======================================================================
`include "dvi_macros.svh"
`default_nettype none

package dvi_timing_pkg;

  // phase boundaries, counted from the start of the active region
  localparam int H_ACTIVE = `DVI_H_ACTIVE;
  localparam int H_SYNC_BEGIN = `DVI_H_ACTIVE + `DVI_H_FRONT;
  localparam int H_SYNC_END = H_SYNC_BEGIN + `DVI_H_SYNC;
  localparam int H_TOTAL = H_SYNC_END + `DVI_H_BACK;

  localparam int V_ACTIVE = `DVI_V_ACTIVE;
  localparam int V_SYNC_BEGIN = `DVI_V_ACTIVE + `DVI_V_FRONT;
  localparam int V_SYNC_END = V_SYNC_BEGIN + `DVI_V_SYNC;
  localparam int V_TOTAL = V_SYNC_END + `DVI_V_BACK;

  typedef logic [$clog2(H_TOTAL)-1:0] h_count_t;
  typedef logic [$clog2(V_TOTAL)-1:0] v_count_t;

  typedef enum logic [1:0] {
    PHASE_ACTIVE,
    PHASE_FRONT,
    PHASE_SYNC,
    PHASE_BACK
  } sync_phase_t;

endpackage

`default_nettype wire

// ==== src/dvi_top.sv ====
// ======================================================================
// encoder setup first, video starts the cycle after iic_done
// the ddr cell and clock pins live outside; both halves leave as ports
// ======================================================================
`default_nettype none

module dvi_top
  import dvi_pixel_pkg::*;
(
  input  wire         clock,
  input  wire         reset,
  input  wire         word_valid,
  input  wire  [63:0] word_data,
  input  wire         sda_in,
  output logic        credit_return,
  output logic        scl,
  output logic        sda_oe,
  output logic        dvi_hs,
  output logic        dvi_vs,
  output logic        dvi_de,
  output logic [11:0] dvi_d_rise,
  output logic [11:0] dvi_d_fall,
  output logic        dvi_reset_n,
  output logic        iic_done,
  output logic        iic_error,
  output logic        underflow
);

  dvi_sync_if sync_bus ();

  logic video_en;       // raster held at h 0, v 0 until set
  logic buf_empty;
  logic pop;
  pixel_pair_t head;

  assign dvi_reset_n = ~reset;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) video_en <= 1'b0;
    else if (iic_done) video_en <= 1'b1;
  end

  dvi_iic_init u_iic_init (
    .clock (clock),
    .reset (reset),
    .sda_in(sda_in),
    .scl   (scl),
    .sda_oe(sda_oe),
    .done  (iic_done),
    .error (iic_error)
  );

  dvi_sync_gen u_sync_gen (
    .clock(clock),
    .reset(reset),
    .run  (video_en),
    .sync (sync_bus.source)
  );

  dvi_pixel_buffer u_pixel_buffer (
    .clock        (clock),
    .reset        (reset),
    .word_valid   (word_valid),
    .word_data    (word_data),
    .pop          (pop),
    .head         (head),
    .empty        (buf_empty),
    .credit_return(credit_return)
  );

  dvi_ddr_out u_ddr_out (
    .clock    (clock),
    .reset    (reset),
    .head     (head),
    .empty    (buf_empty),
    .sync     (sync_bus.sink),
    .pop      (pop),
    .hs       (dvi_hs),
    .vs       (dvi_vs),
    .de       (dvi_de),
    .d_rise   (dvi_d_rise),
    .d_fall   (dvi_d_fall),
    .underflow(underflow)
  );

endmodule

`default_nettype wire

// ==== verification/dvi_checker.sv ====
// ======================================================================
// concurrent rules on the dvi_top outputs, bound into the DUT
// ======================================================================
`default_nettype none

module dvi_checker (
  input wire        clock,
  input wire        reset,
  input wire        dvi_hs,
  input wire        dvi_vs,
  input wire        dvi_de,
  input wire [11:0] dvi_d_rise,
  input wire [11:0] dvi_d_fall,
  input wire        credit_return,
  input wire        iic_done,
  input wire        iic_error,
  input wire        underflow
);
  timeunit 1ns;
  timeprecision 100ps;

  // sync idle until the encoder is set up
  idle_before_init: assert property (@(posedge clock) disable iff (reset)
    !iic_done |-> (dvi_hs && dvi_vs && !dvi_de))
    else $error("video outputs left idle state before iic_done");

  blank_is_black: assert property (@(posedge clock) disable iff (reset)
    !dvi_de |-> (dvi_d_rise == 12'h000 && dvi_d_fall == 12'h000))
    else $error("pixel data outside dvi_de");

  no_de_in_sync: assert property (@(posedge clock) disable iff (reset)
    (!dvi_hs || !dvi_vs) |-> !dvi_de)
    else $error("dvi_de high during a sync pulse");

  credit_single: assert property (@(posedge clock) disable iff (reset)
    credit_return |=> !credit_return)
    else $error("credit_return high for two cycles");

  underflow_sticky: assert property (@(posedge clock) disable iff (reset)
    underflow |=> underflow)
    else $error("underflow dropped before reset");

  done_sticky: assert property (@(posedge clock) disable iff (reset)
    iic_done |=> iic_done)
    else $error("iic_done dropped");

  no_nak: assert property (@(posedge clock) disable iff (reset) !iic_error)
    else $error("encoder did not acknowledge");

endmodule

`default_nettype wire

// ==== verification/dvi_tb.sv ====
// ======================================================================
// credited random source and i2c responder around dvi_top
// one full active line is starved on purpose in the second frame
// ======================================================================
`include "dvi_macros.svh"
`default_nettype none

module dvi_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int H_ACTIVE = `DVI_H_ACTIVE;
  localparam int H_TOTAL = `DVI_H_ACTIVE + `DVI_H_FRONT + `DVI_H_SYNC + `DVI_H_BACK;
  localparam int V_ACTIVE = `DVI_V_ACTIVE;
  localparam int V_TOTAL = `DVI_V_ACTIVE + `DVI_V_FRONT + `DVI_V_SYNC + `DVI_V_BACK;
  localparam int DEPTH = `DVI_BUF_DEPTH;
  localparam int COUNT = `DVI_IIC_COUNT;
  localparam int LIMIT = 2 * (COUNT * 3 * 9 * 4 * `DVI_IIC_DIV + H_TOTAL * V_TOTAL * 3);
  localparam logic [COUNT*16-1:0] TABLE = `DVI_IIC_TABLE;

  logic clock = 1'b0;
  logic reset = 1'b1;
  logic word_valid = 1'b0;
  logic [63:0] word_data = '0;
  logic sda_in = 1'b1;
  logic credit_return, scl, sda_oe, dvi_hs, dvi_vs, dvi_de;
  logic dvi_reset_n, iic_done, iic_error, underflow;
  logic [11:0] dvi_d_rise, dvi_d_fall;

  logic [31:0] lfsr = 32'd89768;
  logic [23:0] pixel_q[$];      // scoreboard in lo then hi order
  logic [7:0] byte_q[$];        // bytes seen on the i2c bus
  logic [7:0] shreg = '0;
  logic [23:0] exp_pix;
  bit prev_scl = 1'b1, prev_sda = 1'b1, ack_drive = 1'b0, sda_line;
  bit stall_req = 1'b0, done_seen = 1'b0;
  int credits = DEPTH, stall_left = 0, bit_cnt = 0, stops = 0, cycles = 0;
  int de_run = 0, hs_run = 0, hs_since = -1, vs_run = 0, de_lines = 0, frames = 0;
  int credit_pulses = 0, pixels_shown = 0, words_shown = 0, zero_cycles = 0;
  int err_reset = 0, err_init = 0, err_raster = 0, err_pixel = 0;
  int err_credit = 0, err_under = 0, total;

  dvi_top dut_i (.*);

  bind dvi_top dvi_checker checker_i (.*);

  // galois lfsr stepped once per bit taken
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
    end
    return v;
  endfunction

  function automatic bit value_ok(input string name, input logic [31:0] got, exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic report(input string name, input int errs);
    $display("test %s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  initial begin
    forever #20 clock = ~clock;
  end

  // ====================================================================
  // credited source
  // ====================================================================
  always @(posedge clock) begin
    if (!reset) begin
      if (credit_return) begin
        credits++;
        credit_pulses++;
      end
      word_valid <= 1'b0;
      if (!stall_req && credits > 0) begin
        if (stall_left > 0) begin
          stall_left--;
        end else begin
          word_data <= take_bits(64);
          word_valid <= 1'b1;
          credits--;
          stall_left = int'(take_bits(1));
        end
      end
      if (credits > DEPTH) begin
        $display("source holds %0d credits, more than the buffer depth", credits);
        err_credit++;
      end
    end
  end

  // the word driven above is visible here one cycle later
  always @(posedge clock) begin
    if (word_valid) begin
      pixel_q.push_back(word_data[23:0]);
      pixel_q.push_back(word_data[55:32]);
    end
  end

  // i2c responder that acks every byte
  always @(posedge clock) begin
    sda_line = !sda_oe && !ack_drive;
    if (scl && prev_scl && prev_sda && !sda_line) begin
      bit_cnt = 0;                            // start
    end else if (scl && prev_scl && !prev_sda && sda_line) begin
      stops++;
    end else if (scl && !prev_scl && bit_cnt < 8) begin
      shreg = {shreg[6:0], sda_line};
      bit_cnt++;
      if (bit_cnt == 8) byte_q.push_back(shreg);
    end else if (!scl && prev_scl) begin
      if (ack_drive) begin
        ack_drive = 1'b0;
        bit_cnt = 0;
      end else if (bit_cnt == 8) begin
        ack_drive = 1'b1;
      end
    end
    prev_scl = scl;
    prev_sda = sda_line;
    sda_in <= !sda_oe && !ack_drive;
  end

  // ====================================================================
  // output monitor sampled mid cycle
  // ====================================================================
  always @(negedge clock) begin
    if (dvi_reset_n !== ~reset) begin
      $display("dvi_reset_n does not follow the inverse of reset");
      err_reset++;
    end
    if (!done_seen) begin
      if (dvi_de || !dvi_hs || !dvi_vs || credit_return) begin
        $display("video outputs active before iic_done");
        err_reset++;
      end
      if (iic_done) begin
        done_seen = 1'b1;
        if (stops != COUNT || iic_error) begin
          $display("iic_done after %0d stops, error %0b", stops, iic_error);
          err_init++;
        end
        if (byte_q.size() != COUNT * 3) begin
          $display("%0d i2c bytes seen, %0d expected", byte_q.size(), COUNT * 3);
          err_init++;
        end else begin
          for (int i = 0; i < COUNT; i++) begin
            if (!value_ok("iic addr", 32'(byte_q[i*3]), {24'h0, 7'(`DVI_IIC_ADDR), 1'b0}))
              err_init++;
            if (!value_ok("iic reg", 32'(byte_q[i*3+1]), 32'(TABLE[i*16+8 +: 8])))
              err_init++;
            if (!value_ok("iic value", 32'(byte_q[i*3+2]), 32'(TABLE[i*16 +: 8])))
              err_init++;
          end
        end
        report("reset", err_reset);
        report("init", err_init);
      end
    end else begin
      if (dvi_de) begin
        de_run++;
        if (pixel_q.size() != 0) begin
          exp_pix = pixel_q.pop_front();
          if (!value_ok("dvi_d_rise", 32'(dvi_d_rise), 32'(exp_pix[11:0]))) err_pixel++;
          if (!value_ok("dvi_d_fall", 32'(dvi_d_fall), 32'(exp_pix[23:12]))) err_pixel++;
          if (zero_cycles == 0 && underflow) begin
            $display("underflow set before the stall");
            err_under++;
          end
          pixels_shown++;
          if (pixels_shown % 2 == 0) words_shown++;
        end else begin
          zero_cycles++;
          if (!stall_req) begin
            $display("buffer ran dry outside the stalled lines");
            err_under++;
          end
          if (!value_ok("dvi_d_rise", 32'(dvi_d_rise), 32'h0)) err_under++;
          if (!value_ok("dvi_d_fall", 32'(dvi_d_fall), 32'h0)) err_under++;
          if (!value_ok("underflow", 32'(underflow), 32'h1)) err_under++;
        end
      end else if (de_run != 0) begin
        if (!value_ok("dvi_de run", 32'(de_run), 32'(H_ACTIVE))) err_raster++;
        de_run = 0;
        de_lines++;
        if (frames == 1 && de_lines == 4) stall_req = 1'b1;   // starve lines 4 and 5
        if (de_lines == V_ACTIVE) stall_req = 1'b0;
      end
      if (!dvi_hs) begin
        if (hs_run == 0) begin
          if (hs_since > 0 && !value_ok("dvi_hs period", 32'(hs_since), 32'(H_TOTAL)))
            err_raster++;
          hs_since = 0;
        end
        hs_run++;
      end else if (hs_run != 0) begin
        if (!value_ok("dvi_hs low", 32'(hs_run), 32'(`DVI_H_SYNC))) err_raster++;
        hs_run = 0;
      end
      if (hs_since >= 0) hs_since++;     // clocks since the last hs fall
      if (!dvi_vs) begin
        if (vs_run == 0) begin
          if (!value_ok("active lines", 32'(de_lines), 32'(V_ACTIVE))) err_raster++;
          de_lines = 0;
        end
        vs_run++;
      end else if (vs_run != 0) begin
        if (!value_ok("dvi_vs low", 32'(vs_run), 32'(`DVI_V_SYNC * H_TOTAL))) err_raster++;
        vs_run = 0;
        frames++;
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout, run passed %0d cycles", LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ====================================================================
  // sequence
  // ====================================================================
  initial begin
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    wait (frames == 3);
    repeat (4) @(posedge clock);
    if (credit_pulses != words_shown) begin
      $display("%0d credit pulses for %0d words shown", credit_pulses, words_shown);
      err_credit++;
    end
    if (zero_cycles < H_ACTIVE || !underflow) begin
      $display("stalled line gave %0d blank pixels, underflow %0b", zero_cycles, underflow);
      err_under++;
    end
    report("raster", err_raster);
    report("pixels", err_pixel);
    report("credits", err_credit);
    report("underflow", err_under);
    total = err_reset + err_init + err_raster + err_pixel + err_credit + err_under;
    $display("6 tests run, %0d errors, %0d pixels checked", total, pixels_shown);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/dvi_timing_pkg.sv
src/dvi_pixel_pkg.sv
src/dvi_sync_if.sv
src/dvi_iic_init.sv
src/dvi_sync_gen.sv
src/dvi_pixel_buffer.sv
src/dvi_ddr_out.sv
src/dvi_top.sv
verification/dvi_checker.sv
verification/dvi_tb.sv
